//--- all.f
logic/bmc_pkg.sv
logic/wb_if.sv
logic/lc_cfg_if.sv
logic/bus_decoder.sv
logic/level_checker_regs.sv
logic/level_checker.sv
logic/irq_controller.sv
logic/bus_monitor.sv
logic/bmc_top.sv
dv/bmc_tb.sv

//--- dv/bmc_tb.sv
`timescale 1ns/1ps

module bmc_tb;
  import bmc_pkg::*;

  localparam int MAX_WORDS    = 192;  // Three words per test line.
  localparam int RESP_TIMEOUT = 20;

  logic        gclk40;
  logic        hard_reset;
  logic        host_cyc;
  logic        host_stb;
  logic        host_we;
  addr_t       host_adr;
  data_t       host_dat_wr;
  data_t       host_dat_rd;
  logic        host_ack;
  logic        host_err;
  logic        adc_strb;
  adc_t        adc_result;
  chan_t       adc_channel;
  logic        irq;
  logic [15:0] tests_mem [MAX_WORDS];

  bmc_top dut0 (
    .gclk40        (gclk40),
    .hard_reset    (hard_reset),
    .host_cyc_i    (host_cyc),
    .host_stb_i    (host_stb),
    .host_we_i     (host_we),
    .host_adr_i    (host_adr),
    .host_dat_i    (host_dat_wr),
    .host_dat_o    (host_dat_rd),
    .host_ack_o    (host_ack),
    .host_err_o    (host_err),
    .adc_strb_i    (adc_strb),
    .adc_result_i  (adc_result),
    .adc_channel_i (adc_channel),
    .irq_o         (irq)
  );

  always #50 gclk40 = ~gclk40;  // 100 ns period.

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s, expected %h, got %h",
                              $time, what, exp, got));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s, expected %b, got %b",
                              $time, what, exp, got));
    end
  endtask

  task automatic check_count(input bm_count_t got, input bm_count_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED at %0t ns: %s, expected %0d, got %0d",
                              $time, what, exp, got));
    end
  endtask

  // One host cycle. Outputs are sampled on the falling edge.
  task automatic bus_access(input logic we, input addr_t adr, input data_t wdat,
                            output data_t rdat, output logic ack, output logic err);
    int waited;
    @(posedge gclk40);
    #5;
    host_cyc    = 1'b1;
    host_stb    = 1'b1;
    host_we     = we;
    host_adr    = adr;
    host_dat_wr = wdat;
    @(negedge gclk40);
    check_flag(host_ack | host_err, 1'b0, $sformatf("early response at %h", adr));
    @(posedge gclk40);  // Stb accepted here.
    waited = 0;
    ack    = 1'b0;
    err    = 1'b0;
    rdat   = '0;
    while (!ack && !err) begin
      @(negedge gclk40);
      waited++;
      ack  = host_ack;
      err  = host_err;
      rdat = host_dat_rd;
      if (waited > RESP_TIMEOUT) begin
        stop_on_error($sformatf("Timeout: no ack or err for the access to %h", adr));
      end
    end
    check_flag(logic'(waited == 1), 1'b1, $sformatf("response latency at %h", adr));
    @(posedge gclk40);
    #5;
    host_cyc = 1'b0;  // Dropped in the cycle after the response.
    host_stb = 1'b0;
    host_we  = 1'b0;
    @(negedge gclk40);
    check_flag(host_ack | host_err, 1'b0, $sformatf("second response cycle at %h", adr));
  endtask

  task automatic adc_sample(input chan_t ch, input adc_t res);
    @(posedge gclk40);
    #5;
    adc_strb    = 1'b1;
    adc_channel = ch;
    adc_result  = res;
    @(posedge gclk40);
    #5;
    adc_strb = 1'b0;
  endtask

  initial begin
    int          idx;
    int          ops;
    logic        done;
    logic [15:0] op;
    logic [15:0] a;
    logic [15:0] b;
    data_t       rdat;
    logic        ack;
    logic        err;
    gclk40      = 1'b0;
    hard_reset  = 1'b0;
    host_cyc    = 1'b0;
    host_stb    = 1'b0;
    host_we     = 1'b0;
    host_adr    = '0;
    host_dat_wr = '0;
    adc_strb    = 1'b0;
    adc_result  = '0;
    adc_channel = '0;
    $readmemh("dv/bmc_tests.txt", tests_mem);
    repeat (16) @(posedge gclk40);
    #5;
    hard_reset = 1'b1;
    idx  = 0;
    ops  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx + 3 > MAX_WORDS) begin
        stop_on_error("The test file ended without its end marker");
      end
      op  = tests_mem[idx];
      a   = tests_mem[idx + 1];
      b   = tests_mem[idx + 2];
      idx = idx + 3;
      ops++;
      case (op)
        16'h0: done = 1'b1;
        16'h1: begin
          bus_access(1'b1, a, b, rdat, ack, err);
          check_flag(ack, 1'b1, $sformatf("write ack at %h", a));
        end
        16'h2: begin
          bus_access(1'b0, a, '0, rdat, ack, err);
          check_flag(ack, 1'b1, $sformatf("read ack at %h", a));
          check_data(rdat, b, $sformatf("read data at %h", a));
        end
        16'h3: adc_sample(chan_t'(a), adc_t'(b));
        16'h4: begin
          repeat (3) @(negedge gclk40);  // Pulse, status, then irq_o.
          check_flag(irq, b[0], "irq_o level");
        end
        16'h5: begin
          bus_access(b[0], a, '0, rdat, ack, err);
          check_flag(err, 1'b1, $sformatf("err for unmapped %h", a));
          check_flag(ack, 1'b0, $sformatf("no ack for unmapped %h", a));
        end
        16'h6: begin
          bus_access(1'b0, a, '0, rdat, ack, err);
          check_flag(ack, 1'b1, $sformatf("read ack at %h", a));
          check_count(bm_count_t'(rdat[7:0]), bm_count_t'(b[7:0]), "bus monitor count");
        end
        default: stop_on_error($sformatf("Unknown operation %h in the test file", op));
      endcase
    end
    if (ops < 2) begin
      stop_on_error("The test file holds no tests");
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- dv/bmc_tests.txt
// Columns, hex: op addr data. 1 write, 2 read and compare, 3 ADC sample (addr is channel),
// 4 expect irq_o level, 5 expect err (data is the write flag), 6 expect count, 0 end.
2 0101 0fff
1 0106 0064
1 0107 00c8
2 0106 0064
2 0107 00c8
1 0111 0008
2 0111 0008
1 0110 0000
2 0110 00ff
1 0201 0001
2 0201 0001
// Window edges on channel 3, then a violation.
3 0003 0064
3 0003 00c8
3 0003 0096
4 0000 0000
2 0110 00ff
3 0003 00c9
4 0000 0001
2 0110 00f7
2 0200 0001
1 0200 0001
4 0000 0000
2 0200 0000
3 0003 0096
2 0110 00ff
// Channel 5 is disabled, so a sample outside its window is ignored.
1 010b 0010
3 0005 0800
4 0000 0000
2 0110 00ff
2 0200 0000
// Masked source still sets status.
1 0201 0000
3 0003 00c9
4 0000 0000
2 0200 0001
1 0200 0001
// Unmapped regions and the bus monitor.
5 0700 0000
2 0200 0002
1 0200 0002
1 0300 0000
5 0712 0000
5 0834 0001
2 0300 0712
2 0301 0002
6 0301 0002
1 0300 0000
6 0301 0000
2 0300 0000
0 0000 0000

//--- logic/bmc_pkg.sv
package bmc_pkg;

  // Bus widths.
  typedef logic [15:0] data_t;
  typedef logic [15:0] addr_t;     // Region in [15:8], offset in [7:0].

  // ADC sample and channel.
  typedef logic [11:0] adc_t;
  typedef logic [2:0]  chan_t;
  typedef logic [7:0]  chan_mask_t;  // One bit per channel.

  // Bit 0 is a level violation, bit 1 a bus memory violation.
  typedef logic [1:0]  irq_vec_t;

  typedef logic [7:0]  bm_count_t;

  localparam int NUM_CHANNELS = 8;
  localparam int NUM_SLAVES   = 3;

  // Region byte of the memory map.
  localparam logic [7:0] REGION_LC  = 8'd1;
  localparam logic [7:0] REGION_IRQ = 8'd2;
  localparam logic [7:0] REGION_BM  = 8'd3;

  // Level checker. Channel c has low at 2c and high at 2c+1.
  localparam logic [7:0] LC_THRESH_OFS   = 8'd0;
  localparam logic [7:0] LC_IN_RANGE_OFS = 8'd16;  // Read only.
  localparam logic [7:0] LC_ENABLE_OFS   = 8'd17;

  // IRQ controller.
  localparam logic [7:0] IRQ_STATUS_OFS = 8'd0;  // Write 1 to clear.
  localparam logic [7:0] IRQ_MASK_OFS   = 8'd1;

  // Bus monitor.
  localparam logic [7:0] BM_ADDR_OFS = 8'd0;  // Any write clears the monitor.
  localparam logic [7:0] BM_INFO_OFS = 8'd1;  // Write flag in bit 8, count below.

  // Slave positions on the decoder.
  localparam int SLV_LC  = 0;
  localparam int SLV_IRQ = 1;
  localparam int SLV_BM  = 2;

endpackage

//--- logic/bmc_top.sv
`timescale 1ns/1ps

module bmc_top (
  input  logic           gclk40,
  input  logic           hard_reset,
  input  logic           host_cyc_i,
  input  logic           host_stb_i,
  input  logic           host_we_i,
  input  bmc_pkg::addr_t host_adr_i,
  input  bmc_pkg::data_t host_dat_i,
  output bmc_pkg::data_t host_dat_o,
  output logic           host_ack_o,
  output logic           host_err_o,
  input  logic           adc_strb_i,
  input  bmc_pkg::adc_t  adc_result_i,
  input  bmc_pkg::chan_t adc_channel_i,
  output logic           irq_o
);
  import bmc_pkg::*;

  wb_if     slv_bus [NUM_SLAVES] ();
  lc_cfg_if lc_cfg ();

  logic     soft_viol;
  logic     bm_memv;
  logic     bm_we;
  addr_t    bm_addr;
  irq_vec_t irq_src;

  assign irq_src = {bm_memv, soft_viol};  // Level violation in bit 0.

  bus_decoder bus_decoder_inst (
    .gclk40     (gclk40),     .hard_reset (hard_reset),
    .host_cyc_i (host_cyc_i), .host_stb_i (host_stb_i), .host_we_i (host_we_i),
    .host_adr_i (host_adr_i), .host_dat_i (host_dat_i), .host_dat_o (host_dat_o),
    .host_ack_o (host_ack_o), .host_err_o (host_err_o),
    .slv        (slv_bus),
    .bm_memv_o  (bm_memv),    .bm_we_o    (bm_we),      .bm_addr_o  (bm_addr)
  );

  level_checker_regs level_checker_regs_inst (
    .gclk40     (gclk40),     .hard_reset (hard_reset),
    .bus        (slv_bus[SLV_LC]),
    .cfg        (lc_cfg)
  );

  level_checker level_checker_inst (
    .gclk40        (gclk40),        .hard_reset   (hard_reset),
    .adc_strb_i    (adc_strb_i),    .adc_result_i (adc_result_i),
    .adc_channel_i (adc_channel_i),
    .cfg           (lc_cfg),
    .soft_viol_o   (soft_viol)
  );

  irq_controller irq_controller_inst (
    .gclk40     (gclk40),     .hard_reset (hard_reset),
    .bus        (slv_bus[SLV_IRQ]),
    .irq_src_i  (irq_src),    .irq_o      (irq_o)
  );

  bus_monitor bus_monitor_inst (
    .gclk40     (gclk40),     .hard_reset (hard_reset),
    .bus        (slv_bus[SLV_BM]),
    .bm_memv_i  (bm_memv),    .bm_we_i    (bm_we),      .bm_addr_i  (bm_addr)
  );

endmodule

//--- logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic           gclk40,
  input  logic           hard_reset,
  input  logic           host_cyc_i,
  input  logic           host_stb_i,
  input  logic           host_we_i,
  input  bmc_pkg::addr_t host_adr_i,
  input  bmc_pkg::data_t host_dat_i,
  output bmc_pkg::data_t host_dat_o,
  output logic           host_ack_o,
  output logic           host_err_o,
  wb_if.dec              slv [bmc_pkg::NUM_SLAVES],
  output logic           bm_memv_o,
  output logic           bm_we_o,
  output bmc_pkg::addr_t bm_addr_o
);
  import bmc_pkg::*;

  logic [NUM_SLAVES-1:0] sel;
  logic [NUM_SLAVES-1:0] ack_vec;
  data_t                 rd_data [NUM_SLAVES];
  logic                  host_req;
  logic                  unmapped;
  logic                  viol_q;

  assign host_req = host_cyc_i & host_stb_i;
  assign unmapped = host_req & ~(|sel) & ~viol_q;  // One err per held request.

  // Region byte to one-hot slave select.
  always_comb begin
    sel = '0;
    case (host_adr_i[15:8])
      REGION_LC:  sel[SLV_LC]  = 1'b1;
      REGION_IRQ: sel[SLV_IRQ] = 1'b1;
      REGION_BM:  sel[SLV_BM]  = 1'b1;
      default:    sel = '0;
    endcase
  end

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slv
    assign slv[i].cyc   = host_cyc_i & sel[i];
    assign slv[i].stb   = host_stb_i & sel[i];
    assign slv[i].we    = host_we_i;
    assign slv[i].adr   = host_adr_i;
    assign slv[i].dat_w = host_dat_i;
    assign ack_vec[i]   = slv[i].ack;
    assign rd_data[i]   = slv[i].dat_r;
  end

  always_comb begin
    host_dat_o = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (sel[i]) begin
        host_dat_o = rd_data[i];
      end
    end
  end

  assign host_ack_o = |ack_vec;

  // Err and memv share one flop.
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      viol_q <= 1'b0;
    end else begin
      viol_q <= unmapped;
    end
  end

  always_ff @(posedge gclk40) begin
    if (unmapped) begin
      bm_addr_o <= host_adr_i;  // Offending access.
      bm_we_o   <= host_we_i;
    end
  end

  assign host_err_o = viol_q;
  assign bm_memv_o  = viol_q;

endmodule

//--- logic/bus_monitor.sv
`timescale 1ns/1ps

module bus_monitor (
  input logic           gclk40,
  input logic           hard_reset,
  wb_if.slv             bus,
  input logic           bm_memv_i,
  input logic           bm_we_i,
  input bmc_pkg::addr_t bm_addr_i
);
  import bmc_pkg::*;

  logic [7:0] ofs;
  logic       accept;
  logic       clr;
  bm_count_t  count_q;
  addr_t      addr_q;
  logic       we_q;
  data_t      rd_mux;

  assign ofs    = bus.adr[7:0];
  assign accept = bus.cyc & bus.stb & ~bus.ack;
  assign clr    = accept & bus.we & (ofs == BM_ADDR_OFS);

  always_ff @(posedge gclk40) begin
    if (!hard_reset || clr) begin
      count_q <= '0;
      addr_q  <= '0;
      we_q    <= 1'b0;
    end else if (bm_memv_i) begin
      if (count_q == '0) begin  // Keep only the first one.
        addr_q <= bm_addr_i;
        we_q   <= bm_we_i;
      end
      if (count_q != '1) begin
        count_q <= count_q + 1'b1;  // Saturates at 255.
      end
    end
  end

  always_comb begin
    case (ofs)
      BM_ADDR_OFS: rd_mux = addr_q;
      BM_INFO_OFS: rd_mux = {7'b0, we_q, count_q};
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= accept;
    end
  end

  always_ff @(posedge gclk40) begin
    if (accept) begin
      bus.dat_r <= rd_mux;
    end
  end

endmodule

//--- logic/irq_controller.sv
`timescale 1ns/1ps

module irq_controller (
  input  logic              gclk40,
  input  logic              hard_reset,
  wb_if.slv                 bus,
  input  bmc_pkg::irq_vec_t irq_src_i,
  output logic              irq_o
);
  import bmc_pkg::*;

  logic [7:0] ofs;
  logic       accept;
  logic       wr_en;
  irq_vec_t   status_q;
  irq_vec_t   mask_q;
  irq_vec_t   clr;
  data_t      rd_mux;

  assign ofs    = bus.adr[7:0];
  assign accept = bus.cyc & bus.stb & ~bus.ack;
  assign wr_en  = accept & bus.we;
  assign clr    = (wr_en && ofs == IRQ_STATUS_OFS) ? irq_vec_t'(bus.dat_w) : '0;

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      status_q <= '0;
      mask_q   <= '0;
      irq_o    <= 1'b0;
    end else begin
      status_q <= (status_q & ~clr) | irq_src_i;  // A new event beats the clear.
      irq_o    <= |(status_q & mask_q);
      if (wr_en && ofs == IRQ_MASK_OFS) begin
        mask_q <= irq_vec_t'(bus.dat_w);
      end
    end
  end

  always_comb begin
    case (ofs)
      IRQ_STATUS_OFS: rd_mux = data_t'(status_q);
      IRQ_MASK_OFS:   rd_mux = data_t'(mask_q);
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= accept;
    end
  end

  always_ff @(posedge gclk40) begin
    if (accept) begin
      bus.dat_r <= rd_mux;
    end
  end

endmodule

//--- logic/lc_cfg_if.sv
`timescale 1ns/1ps

interface lc_cfg_if;
  import bmc_pkg::*;

  adc_t       lo_thresh [NUM_CHANNELS];
  adc_t       hi_thresh [NUM_CHANNELS];
  chan_mask_t enable;
  chan_mask_t in_range;  // Status back from the checker.

  modport regs (output lo_thresh, hi_thresh, enable, input in_range);

  modport chk (input lo_thresh, hi_thresh, enable, output in_range);

endinterface

//--- logic/level_checker.sv
`timescale 1ns/1ps

module level_checker (
  input  logic            gclk40,
  input  logic            hard_reset,
  input  logic            adc_strb_i,
  input  bmc_pkg::adc_t   adc_result_i,
  input  bmc_pkg::chan_t  adc_channel_i,
  lc_cfg_if.chk           cfg,
  output logic            soft_viol_o
);
  import bmc_pkg::*;

  chan_mask_t in_range_q;
  logic       chan_en;
  logic       in_window;

  assign chan_en = cfg.enable[adc_channel_i];

  // Window is inclusive at both ends.
  assign in_window = (adc_result_i >= cfg.lo_thresh[adc_channel_i]) &&
                     (adc_result_i <= cfg.hi_thresh[adc_channel_i]);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      in_range_q  <= '1;    // All channels good until sampled.
      soft_viol_o <= 1'b0;
    end else begin
      soft_viol_o <= adc_strb_i & chan_en & ~in_window;
      if (adc_strb_i && chan_en) begin
        in_range_q[adc_channel_i] <= in_window;
      end
    end
  end

  assign cfg.in_range = in_range_q;

endmodule

//--- logic/level_checker_regs.sv
`timescale 1ns/1ps

module level_checker_regs (
  input logic    gclk40,
  input logic    hard_reset,
  wb_if.slv      bus,
  lc_cfg_if.regs cfg
);
  import bmc_pkg::*;

  logic [7:0] ofs;
  logic [7:0] th_idx;
  chan_t      th_chan;
  logic       th_hit;
  logic       accept;
  logic       wr_en;
  adc_t       lo_q [NUM_CHANNELS];
  adc_t       hi_q [NUM_CHANNELS];
  chan_mask_t enable_q;
  data_t      rd_mux;

  assign ofs     = bus.adr[7:0];
  assign accept  = bus.cyc & bus.stb & ~bus.ack;
  assign wr_en   = accept & bus.we;
  assign th_idx  = ofs - LC_THRESH_OFS;
  assign th_hit  = th_idx < 8'(2 * NUM_CHANNELS);
  assign th_chan = th_idx[$clog2(NUM_CHANNELS):1];  // Bit 0 picks low or high.

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        lo_q[c] <= '0;
        hi_q[c] <= '1;  // Full scale window.
      end
      enable_q <= '0;
    end else if (wr_en) begin
      if (th_hit && th_idx[0]) begin
        hi_q[th_chan] <= adc_t'(bus.dat_w);
      end else if (th_hit) begin
        lo_q[th_chan] <= adc_t'(bus.dat_w);
      end else if (ofs == LC_ENABLE_OFS) begin
        enable_q <= chan_mask_t'(bus.dat_w);
      end
    end
  end

  // Read back. In-range is status only, undefined offsets read 0.
  always_comb begin
    rd_mux = '0;
    if (th_hit) begin
      rd_mux = th_idx[0] ? data_t'(hi_q[th_chan]) : data_t'(lo_q[th_chan]);
    end else if (ofs == LC_IN_RANGE_OFS) begin
      rd_mux = data_t'(cfg.in_range);
    end else if (ofs == LC_ENABLE_OFS) begin
      rd_mux = data_t'(enable_q);
    end
  end

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= accept;
    end
  end

  always_ff @(posedge gclk40) begin
    if (accept) begin
      bus.dat_r <= rd_mux;
    end
  end

  assign cfg.lo_thresh = lo_q;
  assign cfg.hi_thresh = hi_q;
  assign cfg.enable    = enable_q;

endmodule

//--- logic/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
  import bmc_pkg::*;

  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  data_t dat_w;
  data_t dat_r;  // Valid together with ack.
  logic  ack;

  // Decoder side.
  modport dec (output cyc, stb, we, adr, dat_w, input dat_r, ack);

  // Slave side.
  modport slv (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

verilator --binary --timing -f all.f --top-module bmc_tb -o bmc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/bmc_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
